/* ig_pkg.sv */
`default_nettype none

package ig_pkg;

    // --------------------
    // widths
    // --------------------
    localparam int PIXEL_W = 8;
    localparam int GRAD_W  = 10;
    localparam int ADDR_W  = 16;

    // one grayscale sample
    typedef logic [PIXEL_W-1:0] pixel_t;

    // signed forward difference
    typedef logic signed [GRAD_W-1:0] grad_t;

    // address into either memory
    typedef logic [ADDR_W-1:0] addr_t;

    // gx in the upper half, gy in the lower half
    typedef logic [2*GRAD_W-1:0] grad_word_t;

    // --------------------
    // stream beats
    // --------------------
    typedef struct packed {
        pixel_t pix;
        addr_t  addr;
        logic   last_col;
        logic   first_row;
        logic   last;
    } pixel_beat_t;

    typedef struct packed {
        grad_word_t word;
        addr_t      addr;
        logic       last;
    } grad_beat_t;

endpackage

`default_nettype wire

/* image_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module image_reader #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  wire               clk,
    input  wire               reset,
    output logic              img_rd,
    output ig_pkg::addr_t     img_addr,
    input  wire ig_pkg::pixel_t img_di,
    output logic              pix_valid,
    output ig_pkg::pixel_beat_t pix_beat
);
    import ig_pkg::*;

    localparam int COL_W = (IMG_W > 1) ? $clog2(IMG_W) : 1;
    localparam int ROW_W = (IMG_H > 1) ? $clog2(IMG_H) : 1;

    typedef enum logic {
        ST_READING,
        ST_FINISHED
    } state_t;

    state_t           state;
    logic [COL_W-1:0] col;
    logic [ROW_W-1:0] row;
    addr_t            next_addr;
    logic             at_last_col;
    logic             at_last_row;

    // flags of the address currently on img_addr
    logic             iss_last_col;
    logic             iss_first_row;
    logic             iss_last;

    // tags waiting for img_di
    logic             tag_valid;
    addr_t            tag_addr;
    logic             tag_last_col;
    logic             tag_first_row;
    logic             tag_last;

    assign at_last_col = (col == COL_W'(IMG_W - 1));
    assign at_last_row = (row == ROW_W'(IMG_H - 1));

    // --------------------
    // raster address generation
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= ST_READING;
            col       <= '0;
            row       <= '0;
            next_addr <= '0;
            img_rd    <= 1'b0;
            tag_valid <= 1'b0;
        end else begin
            img_rd    <= 1'b0;
            tag_valid <= img_rd;
            case (state)
                ST_READING: begin
                    img_rd    <= 1'b1;
                    next_addr <= next_addr + 1'b1;
                    if (at_last_col) begin
                        col <= '0;
                        row <= row + 1'b1;
                        if (at_last_row) begin
                            state <= ST_FINISHED;
                        end
                    end else begin
                        col <= col + 1'b1;
                    end
                end
                default: begin
                    // image fully issued, stay idle until reset
                end
            endcase
        end
    end

    // address and position flags, then a copy one cycle later
    always_ff @(posedge clk) begin
        img_addr      <= next_addr;
        iss_last_col  <= at_last_col;
        iss_first_row <= (row == '0);
        iss_last      <= at_last_col & at_last_row;

        tag_addr      <= img_addr;
        tag_last_col  <= iss_last_col;
        tag_first_row <= iss_first_row;
        tag_last      <= iss_last;
    end

    // pixel joins its tags as the memory returns it
    assign pix_valid = tag_valid;
    assign pix_beat  = '{
        pix:       img_di,
        addr:      tag_addr,
        last_col:  tag_last_col,
        first_row: tag_first_row,
        last:      tag_last
    };

endmodule

`default_nettype wire

/* gradient_core.sv */
`timescale 1ns/10ps
`default_nettype none

module gradient_core #(
    parameter int IMG_W = 256
) (
    input  wire                      clk,
    input  wire                      reset,
    input  wire                      pix_valid,
    input  wire ig_pkg::pixel_beat_t pix_beat,
    output logic                     grad_valid,
    output ig_pkg::grad_beat_t       grad_beat
);
    import ig_pkg::*;

    localparam int COL_W = (IMG_W > 1) ? $clog2(IMG_W) : 1;

    // --------------------
    // line buffer
    // --------------------
    // entry c holds p(r-1, c) until the pixel of (r, c) replaces it
    pixel_t line_buf [IMG_W];

    logic [COL_W-1:0] col;
    logic [COL_W-1:0] rd_idx;

    // p(r-1, c), fetched on the previous beat
    pixel_t ahead;
    // p(r-1, c+1), read straight from the buffer
    pixel_t upper_right;

    grad_t gx;
    grad_t gy;
    logic  emit;

    grad_word_t word_q;
    addr_t      addr_q;

    // at the row end wrap to entry 0, which already holds
    // the first pixel of the row now finishing
    assign rd_idx      = pix_beat.last_col ? '0 : col + 1'b1;
    assign upper_right = line_buf[rd_idx];

    // --------------------
    // forward differences
    // --------------------
    // 8-bit operands widened to 10 bits, the result spans -255..255
    assign gx = grad_t'({2'b00, upper_right}) - grad_t'({2'b00, ahead});
    assign gy = grad_t'({2'b00, pix_beat.pix}) - grad_t'({2'b00, ahead});

    // no upper row on row 0, no right neighbour in the last column
    assign emit = pix_valid & ~pix_beat.first_row & ~pix_beat.last_col;

    // column pointer and output strobe
    always_ff @(posedge clk) begin
        if (reset) begin
            col        <= '0;
            grad_valid <= 1'b0;
        end else begin
            grad_valid <= emit;
            if (pix_valid) begin
                if (pix_beat.last_col) begin
                    col <= '0;
                end else begin
                    col <= col + 1'b1;
                end
            end
        end
    end

    // buffer update and look-ahead fetch
    always_ff @(posedge clk) begin
        if (pix_valid) begin
            line_buf[col] <= pix_beat.pix;
            ahead         <= upper_right;
        end
    end

    // result register, gradient belongs to the pixel one row up
    always_ff @(posedge clk) begin
        if (emit) begin
            word_q <= {gx, gy};
            addr_q <= pix_beat.addr - addr_t'(IMG_W);
        end
    end

    // pixels stream one per cycle, so the final pixel beat sits at the
    // input exactly while the final gradient is on the output
    assign grad_beat = '{
        word: word_q,
        addr: addr_q,
        last: pix_valid & pix_beat.last
    };

endmodule

`default_nettype wire

/* grad_writer.sv */
`timescale 1ns/10ps
`default_nettype none

module grad_writer (
    input  wire                     clk,
    input  wire                     reset,
    input  wire                     grad_valid,
    input  wire ig_pkg::grad_beat_t grad_beat,
    output logic                    grad_wr,
    output ig_pkg::addr_t           grad_addr,
    output ig_pkg::grad_word_t      grad_do,
    output logic                    done
);
    import ig_pkg::*;

    // high together with the final write
    logic last_wr;

    // --------------------
    // write strobe and completion
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            grad_wr <= 1'b0;
            last_wr <= 1'b0;
            done    <= 1'b0;
        end else begin
            grad_wr <= grad_valid;
            last_wr <= grad_valid & grad_beat.last;
            // sticky until the next reset
            if (last_wr) begin
                done <= 1'b1;
            end
        end
    end

    // --------------------
    // write port payload
    // --------------------
    always_ff @(posedge clk) begin
        if (grad_valid) begin
            grad_addr <= grad_beat.addr;
            grad_do   <= grad_beat.word;
        end
    end

endmodule

`default_nettype wire

/* image_gradient.sv */
`timescale 1ns/10ps
`default_nettype none

module image_gradient #(
    parameter int IMG_W = 256,
    parameter int IMG_H = 256
) (
    input  wire                 clk,
    input  wire                 reset,

    // image memory, read only
    output logic                img_rd,
    output ig_pkg::addr_t       img_addr,
    input  wire ig_pkg::pixel_t img_di,

    // gradient memory, write only
    output logic                grad_wr,
    output ig_pkg::addr_t       grad_addr,
    output ig_pkg::grad_word_t  grad_do,

    output logic                done
);
    import ig_pkg::*;

    logic        pix_valid;
    pixel_beat_t pix_beat;
    logic        grad_valid;
    grad_beat_t  grad_beat;

    // --------------------
    // read side
    // --------------------
    image_reader #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) u_reader (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .pix_valid (pix_valid),
        .pix_beat  (pix_beat)
    );

    // --------------------
    // line buffer and differences
    // --------------------
    gradient_core #(
        .IMG_W (IMG_W)
    ) u_core (
        .clk        (clk),
        .reset      (reset),
        .pix_valid  (pix_valid),
        .pix_beat   (pix_beat),
        .grad_valid (grad_valid),
        .grad_beat  (grad_beat)
    );

    // write side
    grad_writer u_writer (
        .clk        (clk),
        .reset      (reset),
        .grad_valid (grad_valid),
        .grad_beat  (grad_beat),
        .grad_wr    (grad_wr),
        .grad_addr  (grad_addr),
        .grad_do    (grad_do),
        .done       (done)
    );

endmodule

`default_nettype wire

/* tb_memories.sv */
`timescale 1ns/10ps
`default_nettype none

// --------------------
// image ROM, one-cycle read latency
// --------------------
module image_rom #(
    parameter int DEPTH = 256
) (
    input  wire                clk,
    input  wire                rd,
    input  wire ig_pkg::addr_t addr,
    output ig_pkg::pixel_t     dout
);
    import ig_pkg::*;

    // contents are loaded by the testbench before each run
    pixel_t mem [DEPTH];

    initial begin
        dout = '0;
    end

    always @(posedge clk) begin
        if (rd && int'(addr) < DEPTH) begin
            dout <= mem[int'(addr)];
        end
    end

endmodule

// --------------------
// gradient RAM, write port only
// --------------------
module grad_ram #(
    parameter int DEPTH = 256
) (
    input  wire                    clk,
    input  wire                    wr,
    input  wire ig_pkg::addr_t     addr,
    input  wire ig_pkg::grad_word_t din
);
    import ig_pkg::*;

    // filled with a marker by the testbench, read back after the run
    grad_word_t mem [DEPTH];

    always @(posedge clk) begin
        if (wr && int'(addr) < DEPTH) begin
            mem[int'(addr)] <= din;
        end
    end

endmodule

`default_nettype wire

/* tb_image_gradient.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_image_gradient;
    import ig_pkg::*;

    localparam int IMG_W        = 16;
    localparam int IMG_H        = 8;
    localparam int N            = IMG_W * IMG_H;
    localparam int WRITES       = (IMG_W - 1) * (IMG_H - 1);
    localparam int RESET_CYCLES = 8;
    localparam int WATCH_CYCLES = 12;
    localparam int EXTRA_WATCH  = 30;
    localparam int RUN_CYCLES   = RESET_CYCLES + N + 3 + WATCH_CYCLES;
    // four runs, doubled for margin
    localparam int TIMEOUT_CYCLES = 4 * RUN_CYCLES * 2 + EXTRA_WATCH;

    // upper half decodes to +361, which no 8-bit difference can reach
    localparam grad_word_t MARKER    = 20'h5a5a5;
    localparam grad_word_t RAMP_WORD = {10'd1, 10'd2};

    logic       clk = 1'b0;
    logic       reset;
    logic       img_rd;
    addr_t      img_addr;
    pixel_t     img_di;
    logic       grad_wr;
    addr_t      grad_addr;
    grad_word_t grad_do;
    logic       done;

    pixel_t      image [N];
    logic [31:0] rng_state = 32'h05c58b28;
    int          errors = 0;
    int          cycle_count = 0;

    image_gradient #(
        .IMG_W (IMG_W),
        .IMG_H (IMG_H)
    ) UUT (
        .clk       (clk),
        .reset     (reset),
        .img_rd    (img_rd),
        .img_addr  (img_addr),
        .img_di    (img_di),
        .grad_wr   (grad_wr),
        .grad_addr (grad_addr),
        .grad_do   (grad_do),
        .done      (done)
    );

    image_rom #(.DEPTH(N)) u_rom (
        .clk  (clk),
        .rd   (img_rd),
        .addr (img_addr),
        .dout (img_di)
    );

    grad_ram #(.DEPTH(N)) u_ram (
        .clk  (clk),
        .wr   (grad_wr),
        .addr (grad_addr),
        .din  (grad_do)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("errors: %0d", errors);
            $display("Checks failed");
            $finish;
        end
    end

    // --------------------
    // reference model
    // --------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int pix_at(input int r, input int c);
        return int'(image[r * IMG_W + c]);
    endfunction

    // forward differences, gx in the upper 10 bits
    function automatic grad_word_t expected_word(input int r, input int c);
        int gx;
        int gy;
        gx = pix_at(r, c + 1) - pix_at(r, c);
        gy = pix_at(r + 1, c) - pix_at(r, c);
        return {gx[9:0], gy[9:0]};
    endfunction

    // --------------------
    // run and compare
    // --------------------
    task automatic watch_after_done(input string name, input int count);
        repeat (count) begin
            @(posedge clk);
            #1;
            if (done !== 1'b1) begin
                errors++;
                $display("%s: done dropped before the next reset", name);
            end
            if (grad_wr !== 1'b0) begin
                errors++;
                $display("%s: gradient write seen after done", name);
            end
            if (img_rd !== 1'b0) begin
                errors++;
                $display("%s: image read seen after done", name);
            end
        end
    endtask

    task automatic run_image(input string name);
        int cycles;
        int writes;
        int reads;
        for (int i = 0; i < N; i++) begin
            u_rom.mem[i] = image[i];
            u_ram.mem[i] = MARKER;
        end
        reset = 1'b1;
        repeat (RESET_CYCLES) begin
            @(posedge clk);
            #1;
            if (done !== 1'b0 || grad_wr !== 1'b0 || img_rd !== 1'b0) begin
                errors++;
                $display("%s: outputs not idle while reset is high", name);
            end
        end
        reset = 1'b0;
        cycles = 0;
        writes = 0;
        reads = 0;
        while (done !== 1'b1 && cycles < N + 3 + WATCH_CYCLES) begin
            @(posedge clk);
            #1;
            cycles++;
            // reads go out in raster order, one address per cycle
            if (img_rd === 1'b1) begin
                if (int'(img_addr) != reads) begin
                    errors++;
                    $display("** Error at %0t: %s read address %0d, expected %0d",
                             $time, name, img_addr, reads);
                end
                reads++;
            end
            if (grad_wr === 1'b1) begin
                writes++;
                if (int'(grad_addr) >= N) begin
                    errors++;
                    $display("%s: write outside the gradient memory", name);
                end
            end
        end
        if (done !== 1'b1) begin
            errors++;
            $display("%s: done never rose", name);
        end else if (cycles != N + 3) begin
            errors++;
            $display("** Error at %0t: %s done rose after %0d cycles, expected %0d",
                     $time, name, cycles, N + 3);
        end
        if (reads != N) begin
            errors++;
            $display("** Error at %0t: %s saw %0d reads, expected %0d",
                     $time, name, reads, N);
        end
        if (writes != WRITES) begin
            errors++;
            $display("** Error at %0t: %s saw %0d writes, expected %0d",
                     $time, name, writes, WRITES);
        end
        watch_after_done(name, WATCH_CYCLES);
    endtask

    // last row and last column must still hold the marker
    task automatic check_results(input string name);
        grad_word_t exp;
        for (int r = 0; r < IMG_H; r++) begin
            for (int c = 0; c < IMG_W; c++) begin
                if (r < IMG_H - 1 && c < IMG_W - 1) begin
                    exp = expected_word(r, c);
                end else begin
                    exp = MARKER;
                end
                if (u_ram.mem[r * IMG_W + c] !== exp) begin
                    errors++;
                    $display("** Error at %0t: %s (r %0d, c %0d) holds %h, expected %h",
                             $time, name, r, c, u_ram.mem[r * IMG_W + c], exp);
                end
            end
        end
    endtask

    // --------------------
    // directed tests
    // --------------------
    task automatic test_ramp();
        for (int i = 0; i < N; i++) begin
            image[i] = pixel_t'((i % IMG_W) + (i / IMG_W) * 2);
        end
        run_image("ramp");
        check_results("ramp");
        for (int r = 0; r < IMG_H - 1; r++) begin
            for (int c = 0; c < IMG_W - 1; c++) begin
                if (u_ram.mem[r * IMG_W + c] !== RAMP_WORD) begin
                    errors++;
                    $display("** Error at %0t: ramp (r %0d, c %0d) is not gx 1, gy 2",
                             $time, r, c);
                end
            end
        end
    endtask

    // checkerboard of 0 and 255, every difference is +255 or -255
    task automatic test_extremes();
        for (int i = 0; i < N; i++) begin
            image[i] = (((i % IMG_W) + (i / IMG_W)) % 2 == 1) ? 8'd255 : 8'd0;
        end
        run_image("extremes");
        check_results("extremes");
    endtask

    task automatic test_random();
        for (int i = 0; i < N; i++) begin
            rng_state = xorshift32(rng_state);
            image[i]  = rng_state[15:8];
        end
        run_image("random");
        check_results("random");
    endtask

    task automatic test_done_behaviour();
        for (int i = 0; i < N; i++) begin
            image[i] = pixel_t'(255 - i);
        end
        run_image("done");
        check_results("done");
        watch_after_done("done", EXTRA_WATCH);
        reset = 1'b1;
        @(posedge clk);
        #1;
        if (done !== 1'b0) begin
            errors++;
            $display("done: flag not cleared by reset");
        end
    endtask

    initial begin
        reset = 1'b1;
        test_ramp();
        test_extremes();
        test_random();
        test_done_behaviour();
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* image_gradient.f */
ig_pkg.sv
image_reader.sv
gradient_core.sv
grad_writer.sv
image_gradient.sv
tb_memories.sv
tb_image_gradient.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing -Wno-fatal
TOP       = tb_image_gradient
FILELIST  = image_gradient.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_TEXT = All checks passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "$(PASS_TEXT)" $(LOG); then \
		echo "RESULT: PASS"; \
	else \
		echo "RESULT: FAIL"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
